// File: design/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_index_t;
    typedef logic [xlen-1:0] word_t;

    // ----------------------------------------------------------
    // Major opcodes and ALU operations
    // ----------------------------------------------------------
    typedef enum logic [6:0]
    {
        op_imm = 7'b0010011,
        op_reg = 7'b0110011,
        lui    = 7'b0110111,
        auipc  = 7'b0010111,
        jal    = 7'b1101111,
        jalr   = 7'b1100111,
        branch = 7'b1100011,
        load   = 7'b0000011,
        store  = 7'b0100011
    } opcode_t;

    typedef enum logic [3:0]
    {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    // ----------------------------------------------------------
    // Instruction word views
    // ----------------------------------------------------------
    typedef struct packed
    {
        logic [6:0] funct7;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        reg_index_t rd;
        opcode_t    opcode;
    } r_fmt_t;

    typedef struct packed
    {
        logic [11:0] imm;
        reg_index_t  rs1;
        logic [2:0]  funct3;
        reg_index_t  rd;
        opcode_t     opcode;
    } i_fmt_t;

    typedef struct packed
    {
        logic [6:0] imm_11_5;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        opcode_t    opcode;
    } s_fmt_t;

    typedef struct packed
    {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_index_t rs2;
        reg_index_t rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        opcode_t    opcode;
    } b_fmt_t;

    typedef struct packed
    {
        logic [19:0] imm_31_12;
        reg_index_t  rd;
        opcode_t     opcode;
    } u_fmt_t;

    typedef struct packed
    {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        reg_index_t rd;
        opcode_t    opcode;
    } j_fmt_t;

    typedef union packed
    {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
        b_fmt_t b_fmt;
        u_fmt_t u_fmt;
        j_fmt_t j_fmt;
    } instr_u;

    // ADDI x0, x0, 0
    localparam word_t nop_instr = 32'h0000_0013;

    // ----------------------------------------------------------
    // Stage bundles
    // ----------------------------------------------------------
    typedef struct packed
    {
        opcode_t    opcode;
        alu_op_t    alu_op;
        logic [2:0] funct3;
        reg_index_t rs1;
        reg_index_t rs2;
        reg_index_t rd;
        logic       rs1_used;
        logic       rs2_used;
        logic       rd_write;
        logic       alu_src_imm;
        logic       alu_src_pc;
    } decode_ctrl_t;

    typedef struct packed
    {
        decode_ctrl_t ctrl;
        word_t        pc;
        word_t        immediate;
        word_t        operand_1;
        word_t        operand_2;
    } id_ex_t;

    typedef struct packed
    {
        word_t result;
        word_t target;
        logic  redirect;
        word_t address;
    } ex_result_t;

    typedef struct packed
    {
        logic  enable;
        logic  write;
        word_t address;
        word_t write_data;
    } dmem_req_t;

endpackage

// File: design/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage
    import core_pkg::*;
#(
    parameter word_t reset_address = 32'h0000_0000
)
(
    input  logic   CLK,
    input  logic   reset,
    input  logic   stall,
    input  logic   redirect,
    input  word_t  target,
    output word_t  imem_addr,
    input  word_t  imem_data,
    output word_t  decode_pc,
    output instr_u decode_instr
);

    word_t pc;

    assign imem_addr = pc;

    // Program counter
    always_ff @(posedge CLK)
    begin
        if (reset)
            pc <= reset_address;
        else if (redirect)
            pc <= target;
        else if (!stall)
            pc <= pc + 32'd4;
    end

    // Fetch to decode register, flushed to a NOP on a taken jump or branch
    always_ff @(posedge CLK)
    begin
        if (reset || redirect)
            decode_instr <= nop_instr;
        else if (!stall)
        begin
            decode_instr <= imem_data;
            decode_pc    <= pc;
        end
    end

    // A load in execute never redirects, so a bubble and a flush cannot meet
    assert property (@(posedge CLK) disable iff (reset) !(stall && redirect));

endmodule

// File: design/instruction_decoder.sv
`timescale 1ns/1ps

module instruction_decoder
    import core_pkg::*;
(
    input  instr_u       instr,
    output decode_ctrl_t ctrl,
    output word_t        immediate
);

    // Shared funct3 map of OP and OP-IMM; alt selects SUB or SRA
    function automatic alu_op_t funct_to_alu(input logic [2:0] funct3, input logic alt);
        case (funct3)
            3'b000:  return alt ? alu_sub : alu_add;
            3'b001:  return alu_sll;
            3'b010:  return alu_slt;
            3'b011:  return alu_sltu;
            3'b100:  return alu_xor;
            3'b101:  return alt ? alu_sra : alu_srl;
            3'b110:  return alu_or;
            default: return alu_and;
        endcase
    endfunction

    // ----------------------------------------------------------
    // Control fields
    // ----------------------------------------------------------
    always_comb
    begin
        ctrl = '0;
        case (instr.r_fmt.opcode)
            op_reg, op_imm, lui, auipc, jal, jalr, branch, load, store:
            begin
                ctrl.opcode = instr.r_fmt.opcode;
                ctrl.funct3 = instr.i_fmt.funct3;
                ctrl.rs1    = instr.r_fmt.rs1;
                ctrl.rs2    = instr.r_fmt.rs2;
                ctrl.rd     = instr.r_fmt.rd;
                ctrl.alu_op = alu_add;
            end
            default: ;
        endcase

        case (instr.r_fmt.opcode)
            op_reg:
            begin
                ctrl.alu_op   = funct_to_alu(instr.r_fmt.funct3, instr.r_fmt.funct7[5]);
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            op_imm:
            begin
                // Only the shift-right immediate form carries the alternate bit
                ctrl.alu_op = funct_to_alu(instr.i_fmt.funct3,
                    (instr.i_fmt.funct3 == 3'b101) && instr.r_fmt.funct7[5]);
                ctrl.rs1_used    = 1'b1;
                ctrl.rd_write    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            lui:
            begin
                ctrl.alu_op      = alu_pass_b;
                ctrl.rd_write    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            auipc:
            begin
                ctrl.rd_write    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
                ctrl.alu_src_pc  = 1'b1;
            end
            jal:     ctrl.rd_write = 1'b1;
            jalr:
            begin
                ctrl.rs1_used = 1'b1;
                ctrl.rd_write = 1'b1;
            end
            branch:
            begin
                ctrl.rs1_used = 1'b1;
                ctrl.rs2_used = 1'b1;
            end
            load:
            begin
                ctrl.rs1_used    = 1'b1;
                ctrl.rd_write    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            store:
            begin
                ctrl.rs1_used    = 1'b1;
                ctrl.rs2_used    = 1'b1;
                ctrl.alu_src_imm = 1'b1;
            end
            default: ;
        endcase
    end

    // ----------------------------------------------------------
    // Immediate generation
    // ----------------------------------------------------------
    always_comb
    begin
        case (instr.r_fmt.opcode)
            store:
                immediate = {{20{instr.s_fmt.imm_11_5[6]}}, instr.s_fmt.imm_11_5,
                             instr.s_fmt.imm_4_0};
            branch:
                immediate = {{19{instr.b_fmt.imm_12}}, instr.b_fmt.imm_12, instr.b_fmt.imm_11,
                             instr.b_fmt.imm_10_5, instr.b_fmt.imm_4_1, 1'b0};
            lui, auipc:
                immediate = {instr.u_fmt.imm_31_12, 12'b0};
            jal:
                immediate = {{11{instr.j_fmt.imm_20}}, instr.j_fmt.imm_20,
                             instr.j_fmt.imm_19_12, instr.j_fmt.imm_11,
                             instr.j_fmt.imm_10_1, 1'b0};
            default:
                immediate = {{20{instr.i_fmt.imm[11]}}, instr.i_fmt.imm};
        endcase
    end

endmodule

// File: design/register_file.sv
`timescale 1ns/1ps

module register_file
    import core_pkg::*;
(
    input  logic       CLK,
    input  logic       reset,
    input  reg_index_t read_index_1,
    input  reg_index_t read_index_2,
    output word_t      read_data_1,
    output word_t      read_data_2,
    input  logic       write_enable,
    input  reg_index_t write_index,
    input  word_t      write_data
);

    word_t registers [32];

    always_ff @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < 32; i++)
                registers[i] <= '0;
        end
        // x0 stays zero
        else if (write_enable && write_index != '0)
            registers[write_index] <= write_data;
    end

    assign read_data_1 = registers[read_index_1];
    assign read_data_2 = registers[read_index_2];

endmodule

// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit
    import core_pkg::*;
(
    input  id_ex_t     stage,
    output ex_result_t result
);

    word_t alu_a;
    word_t alu_b;
    word_t alu_out;
    logic  taken;
    logic  is_jump;
    logic  [4:0] shamt;

    // ----------------------------------------------------------
    // ALU
    // ----------------------------------------------------------
    assign alu_a = stage.ctrl.alu_src_pc  ? stage.pc        : stage.operand_1;
    assign alu_b = stage.ctrl.alu_src_imm ? stage.immediate : stage.operand_2;
    assign shamt = alu_b[4:0];

    always_comb
    begin
        case (stage.ctrl.alu_op)
            alu_add:    alu_out = alu_a + alu_b;
            alu_sub:    alu_out = alu_a - alu_b;
            alu_sll:    alu_out = alu_a << shamt;
            alu_slt:    alu_out = {31'b0, $signed(alu_a) < $signed(alu_b)};
            alu_sltu:   alu_out = {31'b0, alu_a < alu_b};
            alu_xor:    alu_out = alu_a ^ alu_b;
            alu_srl:    alu_out = alu_a >> shamt;
            alu_sra:    alu_out = word_t'($signed(alu_a) >>> shamt);
            alu_or:     alu_out = alu_a | alu_b;
            alu_and:    alu_out = alu_a & alu_b;
            alu_pass_b: alu_out = alu_b;
            default:    alu_out = '0;
        endcase
    end

    // ----------------------------------------------------------
    // Branch comparison
    // ----------------------------------------------------------
    always_comb
    begin
        case (stage.ctrl.funct3)
            3'b000:  taken = stage.operand_1 == stage.operand_2;
            3'b001:  taken = stage.operand_1 != stage.operand_2;
            3'b100:  taken = $signed(stage.operand_1) < $signed(stage.operand_2);
            3'b101:  taken = $signed(stage.operand_1) >= $signed(stage.operand_2);
            3'b110:  taken = stage.operand_1 < stage.operand_2;
            3'b111:  taken = stage.operand_1 >= stage.operand_2;
            default: taken = 1'b0;
        endcase
    end

    assign is_jump = (stage.ctrl.opcode == jal) || (stage.ctrl.opcode == jalr);

    // Link value replaces the ALU output for jumps
    assign result.result = is_jump ? stage.pc + 32'd4 : alu_out;

    assign result.redirect = is_jump || ((stage.ctrl.opcode == branch) && taken);

    always_comb
    begin
        if (stage.ctrl.opcode == jalr)
            result.target = (stage.operand_1 + stage.immediate) & ~32'd1;
        else
            result.target = stage.pc + stage.immediate;
    end

    // Load and store address
    assign result.address = stage.operand_1 + stage.immediate;

endmodule

// File: design/hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit
    import core_pkg::*;
(
    input  logic         CLK,
    input  logic         reset,
    input  decode_ctrl_t ctrl,
    input  word_t        rf_data_1,
    input  word_t        rf_data_2,
    input  reg_index_t   ex_rd,
    input  logic         ex_write,
    input  logic         ex_load,
    input  word_t        ex_fwd_data,
    input  reg_index_t   mem_rd,
    input  logic         mem_write,
    input  word_t        mem_fwd_data,
    input  reg_index_t   wb_rd,
    input  logic         wb_write,
    input  word_t        wb_data,
    output word_t        operand_1,
    output word_t        operand_2,
    output logic         stall
);

    // Youngest producer wins, x0 always comes from the register file
    function automatic word_t forward(input reg_index_t index, input word_t rf_value);
        if (index == '0)
            return rf_value;
        else if (ex_write && ex_rd == index)
            return ex_fwd_data;
        else if (mem_write && mem_rd == index)
            return mem_fwd_data;
        else if (wb_write && wb_rd == index)
            return wb_data;
        else
            return rf_value;
    endfunction

    assign operand_1 = forward(ctrl.rs1, rf_data_1);
    assign operand_2 = forward(ctrl.rs2, rf_data_2);

    // Load result is not ready until memory stage
    assign stall = ex_load && ex_write && ex_rd != '0 &&
                   ((ctrl.rs1_used && ctrl.rs1 == ex_rd) ||
                    (ctrl.rs2_used && ctrl.rs2 == ex_rd));

    // The bubble moves the load on, so a stall never repeats
    assert property (@(posedge CLK) disable iff (reset) stall |=> !stall);

endmodule

// File: design/rv_core.sv
`timescale 1ns/1ps

module rv_core
    import core_pkg::*;
#(
    parameter word_t reset_address = 32'h0000_0000
)
(
    input  logic      CLK,
    input  logic      reset,
    output word_t     imem_addr,
    input  word_t     imem_data,
    output dmem_req_t dmem_req,
    input  word_t     dmem_rdata
);

    word_t        decode_pc;
    instr_u       decode_instr;
    decode_ctrl_t dec_ctrl;
    word_t        dec_imm;
    word_t        rf_data_1;
    word_t        rf_data_2;
    word_t        operand_1;
    word_t        operand_2;
    logic         stall;

    id_ex_t       id_ex;
    ex_result_t   ex_result;

    decode_ctrl_t mem_ctrl;
    ex_result_t   mem_result;
    word_t        mem_store_data;
    word_t        mem_fwd_data;

    logic         wb_write;
    reg_index_t   wb_rd;
    word_t        wb_data;

    // ----------------------------------------------------------
    // Fetch and decode
    // ----------------------------------------------------------
    fetch_stage #(.reset_address(reset_address)) fetch
    (
        .CLK(CLK), .reset(reset),
        .stall(stall), .redirect(ex_result.redirect), .target(ex_result.target),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .decode_pc(decode_pc), .decode_instr(decode_instr)
    );

    instruction_decoder decoder (.instr(decode_instr), .ctrl(dec_ctrl), .immediate(dec_imm));

    register_file regs
    (
        .CLK(CLK), .reset(reset),
        .read_index_1(dec_ctrl.rs1), .read_index_2(dec_ctrl.rs2),
        .read_data_1(rf_data_1), .read_data_2(rf_data_2),
        .write_enable(wb_write), .write_index(wb_rd), .write_data(wb_data)
    );

    hazard_unit hazard
    (
        .CLK(CLK), .reset(reset),
        .ctrl(dec_ctrl), .rf_data_1(rf_data_1), .rf_data_2(rf_data_2),
        .ex_rd(id_ex.ctrl.rd), .ex_write(id_ex.ctrl.rd_write),
        .ex_load(id_ex.ctrl.opcode == load), .ex_fwd_data(ex_result.result),
        .mem_rd(mem_ctrl.rd), .mem_write(mem_ctrl.rd_write), .mem_fwd_data(mem_fwd_data),
        .wb_rd(wb_rd), .wb_write(wb_write), .wb_data(wb_data),
        .operand_1(operand_1), .operand_2(operand_2), .stall(stall)
    );

    // ----------------------------------------------------------
    // Execute
    // ----------------------------------------------------------
    // All-zero bundle is a bubble: no write, no memory access, no redirect
    always_ff @(posedge CLK)
    begin
        if (reset || stall || ex_result.redirect)
            id_ex <= '0;
        else
            id_ex <= '{ctrl: dec_ctrl, pc: decode_pc, immediate: dec_imm,
                       operand_1: operand_1, operand_2: operand_2};
    end

    execute_unit execute (.stage(id_ex), .result(ex_result));

    // ----------------------------------------------------------
    // Memory
    // ----------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
            mem_ctrl <= '0;
        else
            mem_ctrl <= id_ex.ctrl;
    end

    always_ff @(posedge CLK)
    begin
        mem_result     <= ex_result;
        mem_store_data <= id_ex.operand_2;
    end

    assign dmem_req.enable     = (mem_ctrl.opcode == load) || (mem_ctrl.opcode == store);
    assign dmem_req.write      = mem_ctrl.opcode == store;
    assign dmem_req.address    = mem_result.address;
    assign dmem_req.write_data = mem_store_data;

    // Write-back value, chosen here so it also serves as forwarding data
    assign mem_fwd_data = (mem_ctrl.opcode == load) ? dmem_rdata : mem_result.result;

    assert property (@(posedge CLK) disable iff (reset)
        dmem_req.enable && dmem_req.write |-> dmem_req.address[1:0] == 2'b00);

    // ----------------------------------------------------------
    // Write-back
    // ----------------------------------------------------------
    always_ff @(posedge CLK)
    begin
        if (reset)
            wb_write <= 1'b0;
        else
            wb_write <= mem_ctrl.rd_write;
    end

    always_ff @(posedge CLK)
    begin
        wb_rd   <= mem_ctrl.rd;
        wb_data <= mem_fwd_data;
    end

endmodule

// File: sim/core_tb.sv
`timescale 1ns/1ps

module core_tb
    import core_pkg::*;
();

    localparam int    period          = 100;
    localparam int    reset_cycles    = 10;
    localparam int    poll_limit      = 20;
    localparam int    drain_cycles    = 5;
    localparam int    cycles_per_test = 40;
    localparam word_t reset_address   = 32'h0000_0000;
    localparam word_t result_addr     = 32'h0000_0100;
    localparam word_t data_addr       = 32'h0000_0080;
    // Address of the instruction under test in every program
    localparam word_t test_pc         = 32'h0000_0010;

    typedef enum logic [1:0] {k_arith, k_branch, k_jump, k_load_use} kind_t;

    typedef enum logic [4:0]
    {
        c_add, c_sub, c_sll, c_slt, c_sltu, c_xor, c_srl, c_sra, c_or, c_and,
        c_addi, c_slti, c_sltiu, c_xori, c_ori, c_andi, c_slli, c_srli, c_srai,
        c_lui, c_auipc, c_beq, c_bne, c_blt, c_bge, c_bltu, c_bgeu,
        c_jal, c_jalr, c_lw
    } code_t;

    typedef struct packed
    {
        kind_t kind;
        code_t code;
        word_t op_a;
        word_t op_b;
        word_t expected;
    } test_row_t;

    logic      CLK;
    logic      reset;
    word_t     imem_addr;
    word_t     imem_data;
    dmem_req_t dmem_req;
    word_t     dmem_rdata;

    word_t     imem [256];
    word_t     dmem [256];
    dmem_req_t store_log [$];
    test_row_t tests [$];
    int        n_tests = 0;
    int        test_errors;
    int        passed;
    int        failed;

    rv_core #(.reset_address(reset_address)) UUT
    (
        .CLK(CLK), .reset(reset),
        .imem_addr(imem_addr), .imem_data(imem_data),
        .dmem_req(dmem_req), .dmem_rdata(dmem_rdata)
    );

    initial
    begin
        CLK = 1'b0;
        forever #(period / 2) CLK = ~CLK;
    end

    // ----------------------------------------------------------
    // Memory models
    // ----------------------------------------------------------
    assign imem_data  = imem[imem_addr[9:2]];
    assign dmem_rdata = dmem[dmem_req.address[9:2]];

    // Fill pattern while in reset, every store is logged
    always @(posedge CLK)
    begin
        if (reset)
        begin
            for (int i = 0; i < 256; i++)
                dmem[i] <= 32'hd00d_0000 | word_t'(i * 4);
        end
        else if (dmem_req.enable && dmem_req.write)
        begin
            dmem[dmem_req.address[9:2]] <= dmem_req.write_data;
            store_log.push_back(dmem_req);
        end
    end

    // ----------------------------------------------------------
    // Instruction encoders
    // ----------------------------------------------------------
    function automatic word_t enc_r(logic [6:0] f7, logic [2:0] f3);
        return {f7, 5'd2, 5'd1, f3, 5'd3, op_reg};
    endfunction

    function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                    logic [4:0] rd, opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], store};
    endfunction

    // Compares x1 with x2, taken path lands three words ahead
    function automatic word_t enc_b(logic [2:0] f3);
        logic [12:0] off;
        off = 13'd12;
        return {off[12], off[10:5], 5'd2, 5'd1, f3, off[4:1], off[11], branch};
    endfunction

    function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(logic [20:0] off, logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, jal};
    endfunction

    function automatic logic [2:0] funct3_of(code_t code);
        case (code)
            c_sll, c_slli, c_bne:    return 3'b001;
            c_slt, c_slti:           return 3'b010;
            c_sltu, c_sltiu:         return 3'b011;
            c_xor, c_xori, c_blt:    return 3'b100;
            c_srl, c_srli, c_sra,
            c_srai, c_bge:           return 3'b101;
            c_or, c_ori, c_bltu:     return 3'b110;
            c_and, c_andi, c_bgeu:   return 3'b111;
            default:                 return 3'b000;
        endcase
    endfunction

    function automatic word_t instr_under_test(test_row_t row);
        logic [2:0] f3;
        f3 = funct3_of(row.code);
        case (row.code)
            c_add, c_sll, c_slt, c_sltu, c_xor, c_srl, c_or, c_and:
                return enc_r(7'b0000000, f3);
            c_sub, c_sra:
                return enc_r(7'b0100000, f3);
            c_srai:
                return enc_i({7'b0100000, row.op_b[4:0]}, 5'd1, f3, 5'd3, op_imm);
            c_addi, c_slti, c_sltiu, c_xori, c_ori, c_andi, c_slli, c_srli:
                return enc_i(row.op_b[11:0], 5'd1, f3, 5'd3, op_imm);
            c_lui:   return enc_u(row.op_a[31:12], 5'd3, lui);
            c_auipc: return enc_u(row.op_a[31:12], 5'd3, auipc);
            c_jal:   return enc_j(21'd12, 5'd3);
            c_jalr:  return enc_i(row.op_b[11:0], 5'd1, 3'b000, 5'd3, jalr);
            c_lw:    return enc_i(data_addr[11:0], 5'd0, 3'b010, 5'd4, load);
            default: return enc_b(f3);
        endcase
    endfunction

    // ----------------------------------------------------------
    // Reference values from RV32I semantics
    // ----------------------------------------------------------
    function automatic word_t expected_value(code_t code, word_t a, word_t b);
        case (code)
            c_add, c_addi:   return a + b;
            c_sub:           return a - b;
            c_sll, c_slli:   return a << b[4:0];
            c_slt, c_slti:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            c_sltu, c_sltiu: return (a < b) ? 32'd1 : 32'd0;
            c_xor, c_xori:   return a ^ b;
            c_srl, c_srli:   return a >> b[4:0];
            c_sra, c_srai:   return word_t'($signed(a) >>> b[4:0]);
            c_or, c_ori:     return a | b;
            c_and, c_andi:   return a & b;
            c_lui:           return {a[31:12], 12'h000};
            c_auipc:         return test_pc + {a[31:12], 12'h000};
            // Branches store 1 when taken and 2 when not
            c_beq:           return (a == b) ? 32'd1 : 32'd2;
            c_bne:           return (a != b) ? 32'd1 : 32'd2;
            c_blt:           return ($signed(a) < $signed(b)) ? 32'd1 : 32'd2;
            c_bge:           return ($signed(a) >= $signed(b)) ? 32'd1 : 32'd2;
            c_bltu:          return (a < b) ? 32'd1 : 32'd2;
            c_bgeu:          return (a >= b) ? 32'd1 : 32'd2;
            c_jal, c_jalr:   return test_pc + 32'd4;
            default:         return a + 32'd1;
        endcase
    endfunction

    task automatic add_row(kind_t row_kind, code_t row_code, word_t a, word_t b);
        word_t imm_b;
        case (row_code)
            c_addi, c_slti, c_sltiu, c_xori, c_ori, c_andi, c_jalr:
                imm_b = {{20{b[11]}}, b[11:0]};
            c_slli, c_srli, c_srai:
                imm_b = {27'b0, b[4:0]};
            default:
                imm_b = b;
        endcase
        tests.push_back('{kind: row_kind, code: row_code, op_a: a, op_b: imm_b,
                          expected: expected_value(row_code, a, imm_b)});
    endtask

    task automatic build_table();
        for (int c = c_add; c <= c_auipc; c++)
            add_row(k_arith, code_t'(c), $urandom, $urandom);
        add_row(k_arith, c_sra,  32'h8000_0010, 32'd4);
        add_row(k_arith, c_sltu, 32'hffff_ffff, 32'd1);
        add_row(k_arith, c_slti, 32'hffff_fff0, 32'h0000_0fff);
        // Signed and unsigned order differ for -3 against 2
        add_row(k_branch, c_beq,  32'd5, 32'd5);
        add_row(k_branch, c_beq,  32'd5, 32'd6);
        add_row(k_branch, c_bne,  32'd5, 32'd6);
        add_row(k_branch, c_bne,  32'd5, 32'd5);
        add_row(k_branch, c_blt,  32'hffff_fffd, 32'd2);
        add_row(k_branch, c_blt,  32'd2, 32'hffff_fffd);
        add_row(k_branch, c_bge,  32'd2, 32'hffff_fffd);
        add_row(k_branch, c_bge,  32'hffff_fffd, 32'd2);
        add_row(k_branch, c_bltu, 32'd2, 32'hffff_fffd);
        add_row(k_branch, c_bltu, 32'hffff_fffd, 32'd2);
        add_row(k_branch, c_bgeu, 32'hffff_fffd, 32'd2);
        add_row(k_branch, c_bgeu, 32'd2, 32'hffff_fffd);
        add_row(k_jump, c_jal, 32'd0, 32'd0);
        // 22 + 7 lands on 29, bit 0 cleared gives the store at 28
        add_row(k_jump, c_jalr, 32'd22, 32'd7);
        add_row(k_load_use, c_lw, $urandom, 32'd0);
        add_row(k_load_use, c_lw, $urandom, 32'd0);
    endtask

    // x1 and x2 are set up first, then the sequence for the row's kind
    task automatic load_program(test_row_t row);
        word_t a_hi;
        word_t b_hi;
        a_hi = row.op_a + 32'h800;
        b_hi = row.op_b + 32'h800;
        for (int i = 0; i < 256; i++)
            imem[i] = nop_instr;
        imem[0] = enc_u(a_hi[31:12], 5'd1, lui);
        imem[1] = enc_i(row.op_a[11:0], 5'd1, 3'b000, 5'd1, op_imm);
        imem[2] = enc_u(b_hi[31:12], 5'd2, lui);
        imem[3] = enc_i(row.op_b[11:0], 5'd2, 3'b000, 5'd2, op_imm);
        case (row.kind)
            k_arith:
            begin
                imem[4] = instr_under_test(row);
                imem[5] = enc_s(result_addr[11:0], 5'd3, 5'd0);
                imem[6] = enc_j(21'd0, 5'd0);
            end
            k_branch:
            begin
                imem[4] = instr_under_test(row);
                imem[5] = enc_i(12'd2, 5'd0, 3'b000, 5'd3, op_imm);
                imem[6] = enc_j(21'd8, 5'd0);
                imem[7] = enc_i(12'd1, 5'd0, 3'b000, 5'd3, op_imm);
                imem[8] = enc_s(result_addr[11:0], 5'd3, 5'd0);
                imem[9] = enc_j(21'd0, 5'd0);
            end
            k_jump:
            begin
                imem[4] = instr_under_test(row);
                imem[5] = enc_i(12'd2, 5'd0, 3'b000, 5'd3, op_imm);
                imem[6] = enc_i(12'd3, 5'd0, 3'b000, 5'd3, op_imm);
                imem[7] = enc_s(result_addr[11:0], 5'd3, 5'd0);
                imem[8] = enc_j(21'd0, 5'd0);
            end
            default:
            begin
                imem[4] = enc_s(data_addr[11:0], 5'd1, 5'd0);
                imem[5] = instr_under_test(row);
                imem[6] = enc_i(12'd1, 5'd4, 3'b000, 5'd3, op_imm);
                imem[7] = enc_s(result_addr[11:0], 5'd3, 5'd0);
                imem[8] = enc_j(21'd0, 5'd0);
            end
        endcase
    endtask

    // ----------------------------------------------------------
    // Compare tasks
    // ----------------------------------------------------------
    task automatic check_word(int index, string name, word_t got, word_t exp);
        if (got !== exp)
        begin
            $display("FAIL test %0d: %s = 0x%08h, expected 0x%08h", index, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic check_store(int index, dmem_req_t got, dmem_req_t exp);
        if (got !== exp)
        begin
            $display("FAIL test %0d: dmem_req = {en %h, we %h, addr 0x%08h, data 0x%08h}, %s",
                     index, got.enable, got.write, got.address, got.write_data,
                     $sformatf("expected {en %h, we %h, addr 0x%08h, data 0x%08h}",
                               exp.enable, exp.write, exp.address, exp.write_data));
            test_errors++;
        end
    endtask

    task automatic run_test(int index, test_row_t row);
        dmem_req_t expected_req;
        int        expected_stores;
        int        cycles;
        code_t     code;
        code = row.code;
        test_errors = 0;
        expected_req = '{enable: 1'b1, write: 1'b1, address: result_addr,
                         write_data: row.expected};
        expected_stores = (row.kind == k_load_use) ? 2 : 1;

        @(posedge CLK);
        reset <= 1'b1;
        @(negedge CLK);
        load_program(row);
        store_log.delete();
        repeat (reset_cycles) @(posedge CLK);
        reset <= 1'b0;

        // First fetch after reset comes from the reset address
        @(negedge CLK);
        check_word(index, "imem_addr", imem_addr, reset_address);

        cycles = 0;
        while (store_log.size() < expected_stores && cycles < poll_limit)
        begin
            @(negedge CLK);
            cycles++;
        end

        if (store_log.size() < expected_stores)
        begin
            $display("test %0d (%s): no result store within %0d cycles",
                     index, code.name(), poll_limit);
            test_errors++;
        end
        else
        begin
            // Let flushed or stray instructions show up if they would store
            repeat (drain_cycles) @(negedge CLK);
            if (store_log.size() != expected_stores)
            begin
                $display("test %0d (%s): %0d stores seen where %0d were expected",
                         index, code.name(), store_log.size(), expected_stores);
                test_errors++;
            end
            check_store(index, store_log[expected_stores - 1], expected_req);
        end

        if (test_errors == 0)
        begin
            passed++;
            $display("test %0d %s %s: ok", index, row.kind.name(), code.name());
        end
        else
        begin
            failed++;
            $display("test %0d %s %s: failed", index, row.kind.name(), code.name());
        end
    endtask

    // ----------------------------------------------------------
    // Main sequence and watchdog
    // ----------------------------------------------------------
    initial
    begin
        reset = 1'b1;
        passed = 0;
        failed = 0;
        void'($urandom(32'h8025_5f01));
        build_table();
        n_tests = tests.size();
        foreach (tests[t])
            run_test(t, tests[t]);
        $display("tests run %0d, passed %0d, failed %0d", n_tests, passed, failed);
        if (failed == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    initial
    begin
        wait (n_tests > 0);
        repeat (n_tests * cycles_per_test) @(posedge CLK);
        $display("watchdog: the run did not finish within %0d cycles",
                 n_tests * cycles_per_test);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: vlog.f
design/core_pkg.sv
design/fetch_stage.sv
design/instruction_decoder.sv
design/register_file.sv
design/execute_unit.sv
design/hazard_unit.sv
design/rv_core.sv
sim/core_tb.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = core_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qxF '** PASS **' $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
